//--- divider.f
source/div_params_pkg.sv
source/div_types_pkg.sv
source/div_operand_capture.sv
source/div_controller.sv
source/div_datapath.sv
source/div_result_hold.sv
source/divider_top.sv
tests/divider_tb.sv

//--- source/div_controller.sv
`timescale 1ns/1ps

module div_controller (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load,
    input  logic                     count_done,
    input  logic                     sub_msb,
    output div_types_pkg::div_ctrl_t ctrl,
    output logic                     busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_iterate,
        st_finish
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (load) begin
                    state_next = st_load;
                end
            end
            st_load: begin
                state_next = st_iterate;
            end
            st_iterate: begin
                // count_done flags the final step
                if (count_done) begin
                    state_next = st_finish;
                end
            end
            st_finish: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // Datapath strobes decoded from the current state
    always_comb begin
        ctrl = '0;
        case (state)
            st_load: begin
                ctrl.load_operands = 1'b1;
            end
            st_iterate: begin
                ctrl.iterate = 1'b1;
                // Negative difference means restore A and shift in a zero
                ctrl.keep_difference = ~sub_msb;
                ctrl.write_result = count_done;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // High while the datapath iterates
    assign busy = (state == st_iterate);

endmodule

//--- source/div_datapath.sv
`timescale 1ns/1ps

module div_datapath (
    input  logic                        clk,
    input  logic                        reset,
    input  div_types_pkg::div_request_t captured,
    input  div_types_pkg::div_ctrl_t    ctrl,
    output logic                        sub_msb,
    output logic                        count_done,
    output div_types_pkg::div_result_t  next_result
);

    import div_params_pkg::*;
    import div_types_pkg::*;

    // A carries one extra bit for the sign of the trial subtraction
    logic [div_width:0]           a_reg;
    logic [div_width-1:0]         q_reg;
    logic [div_width-1:0]         m_reg;
    logic [div_count_width-1:0]   count;

    logic [div_width:0]           a_shift;
    logic [div_width-1:0]         q_shift;
    logic [div_width:0]           m_ext;
    logic [div_width:0]           diff;
    logic [div_width:0]           a_next;
    logic [div_width-1:0]         q_next;

    // Operand and partial result registers
    always_ff @(posedge clk) begin
        if (ctrl.load_operands) begin
            a_reg <= '0;
            q_reg <= captured.dividend;
            m_reg <= captured.divisor;
        end else if (ctrl.iterate) begin
            a_reg <= a_next;
            q_reg <= q_next;
        end
    end

    // Iteration counter
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (ctrl.load_operands) begin
            count <= '0;
        end else if (ctrl.iterate) begin
            count <= count + 1'b1;
        end
    end

    // Final step is the one taken with the counter at div_width-1
    assign count_done = (count == div_count_width'(div_width - 1));

    always_comb begin
        // Shift {A, Q} left by one
        a_shift = {a_reg[div_width-1:0], q_reg[div_width-1]};
        q_shift = {q_reg[div_width-2:0], 1'b0};

        // Trial subtraction of the divisor
        m_ext = {1'b0, m_reg};
        diff  = a_shift - m_ext;
    end

    assign sub_msb = diff[div_width];

    // Keep or restore, choice comes from the controller
    always_comb begin
        if (ctrl.keep_difference) begin
            a_next = diff;
            q_next = q_shift | {{(div_width-1){1'b0}}, 1'b1};
        end else begin
            a_next = diff + m_ext;
            q_next = q_shift;
        end
    end

    // Values after this step; divide-by-zero flag is added downstream
    always_comb begin
        next_result.quotient    = q_next;
        next_result.remainder   = a_next[div_width-1:0];
        next_result.div_by_zero = 1'b0;
    end

endmodule

//--- source/div_operand_capture.sv
`timescale 1ns/1ps

module div_operand_capture (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  div_types_pkg::div_request_t request,
    input  logic                       busy,
    output div_types_pkg::div_request_t captured,
    output logic                       divisor_zero,
    output logic                       load
);

    import div_params_pkg::*;

    logic accept;

    // A start is taken only while no division is running
    assign accept = start & ~busy;

    // Request payload, held until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            captured     <= request;
            divisor_zero <= (request.divisor == {div_width{1'b0}});
        end
    end

    // One-cycle load pulse to the controller
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            load <= 1'b0;
        end else begin
            load <= accept;
        end
    end

endmodule

//--- source/div_params_pkg.sv
package div_params_pkg;

    // Operand width of dividend, divisor, quotient and remainder
    parameter int div_width = 16;

    // Iteration counter must be able to hold the value div_width
    parameter int div_count_width = $clog2(div_width + 1);

endpackage

//--- source/div_result_hold.sv
`timescale 1ns/1ps

module div_result_hold (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start_accepted,
    input  logic                       write_result,
    input  div_types_pkg::div_result_t next_result,
    input  logic                       divisor_zero,
    output logic                       done,
    output div_types_pkg::div_result_t result
);

    import div_types_pkg::*;

    div_result_t result_q;
    logic        valid;

    // Result payload with the zero-divisor flag attached
    always_ff @(posedge clk) begin
        if (write_result) begin
            result_q <= '{
                quotient:    next_result.quotient,
                remainder:   next_result.remainder,
                div_by_zero: divisor_zero
            };
        end
    end

    // Valid level and completion pulse
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= write_result;
            if (write_result) begin
                valid <= 1'b1;
            end else if (start_accepted) begin
                valid <= 1'b0;
            end
        end
    end

    // Result reads zero until the division completes
    assign result = valid ? result_q : '0;

endmodule

//--- source/div_types_pkg.sv
package div_types_pkg;

    // One division request as presented at the top level
    typedef struct packed {
        logic [div_params_pkg::div_width-1:0] dividend;
        logic [div_params_pkg::div_width-1:0] divisor;
    } div_request_t;

    // Result of one division
    // div_by_zero marks a request whose divisor was zero
    typedef struct packed {
        logic [div_params_pkg::div_width-1:0] quotient;
        logic [div_params_pkg::div_width-1:0] remainder;
        logic                                 div_by_zero;
    } div_result_t;

    // Strobes from the controller to the datapath
    typedef struct packed {
        // Load M and Q from the captured request, clear A and the counter
        logic load_operands;
        // One shift-subtract-restore step, counter increments
        logic iterate;
        // Keep the difference (1) or restore A (0), chosen from sub_msb
        logic keep_difference;
        // Last step, next A and Q go to the result register
        logic write_result;
    } div_ctrl_t;

endpackage

//--- source/divider_top.sv
`timescale 1ns/1ps

module divider_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  div_types_pkg::div_request_t request,
    output logic                        busy,
    output logic                        done,
    output div_types_pkg::div_result_t  result
);

    import div_types_pkg::*;

    logic         start_accepted;
    div_request_t captured;
    logic         divisor_zero;
    logic         load;
    div_ctrl_t    ctrl;
    logic         sub_msb;
    logic         count_done;
    div_result_t  next_result;

    // Starts while busy are dropped
    assign start_accepted = start & ~busy;

    div_operand_capture u_capture (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .request      (request),
        .busy         (busy),
        .captured     (captured),
        .divisor_zero (divisor_zero),
        .load         (load)
    );

    div_controller u_controller (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .count_done (count_done),
        .sub_msb    (sub_msb),
        .ctrl       (ctrl),
        .busy       (busy)
    );

    div_datapath u_datapath (
        .clk         (clk),
        .reset       (reset),
        .captured    (captured),
        .ctrl        (ctrl),
        .sub_msb     (sub_msb),
        .count_done  (count_done),
        .next_result (next_result)
    );

    div_result_hold u_result_hold (
        .clk            (clk),
        .reset          (reset),
        .start_accepted (start_accepted),
        .write_result   (ctrl.write_result),
        .next_result    (next_result),
        .divisor_zero   (divisor_zero),
        .done           (done),
        .result         (result)
    );

endmodule

//--- tests/divider_tb.sv
`timescale 1ns/1ps

module divider_tb;

    import div_params_pkg::*;
    import div_types_pkg::*;

    localparam int clk_half_period = 10;
    localparam int reset_cycles    = 16;
    localparam int num_random      = 200;
    localparam int num_directed    = 14;
    localparam int num_divisions   = num_random + num_directed;
    localparam int watchdog_cycles = num_divisions * 25 + 100;
    localparam int done_limit      = 30;

    // Sampled edge numbers counted from the accepted start edge (edge 0)
    localparam int busy_first  = 3;
    localparam int busy_last   = div_width + 2;
    localparam int done_edge   = div_width + 3;
    localparam int since_limit = 100;

    logic         clk = 1'b0;
    logic         reset;
    logic         start;
    div_request_t request;
    logic         busy;
    logic         done;
    div_result_t  result;

    div_result_t  exp_result;
    div_result_t  result_prev;
    int           since_accept;
    logic         busy_exp;
    logic         done_exp;
    int           value_errors = 0;
    int           timing_errors = 0;
    int           done_count = 0;
    int           issued_count = 0;

    divider_top dut (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .request (request),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

    always #(clk_half_period) clk = ~clk;

    // Edges elapsed since the last accepted start (0 when none since reset)
    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            since_accept <= 0;
        end else if (start && !busy) begin
            since_accept <= 1;
        end else if (since_accept != 0 && since_accept < since_limit) begin
            since_accept <= since_accept + 1;
        end
    end

    always @(posedge clk) begin
        result_prev <= result;
    end

    assign busy_exp = (since_accept >= busy_first) && (since_accept <= busy_last);
    assign done_exp = (since_accept == done_edge);

    busy_window: assert property (@(posedge clk) disable iff (!reset) busy == busy_exp)
        else begin
            timing_errors++;
            $display("Mismatch at %0t: busy expected %b, got %b",
                     $time, $sampled(busy_exp), $sampled(busy));
        end

    done_timing: assert property (@(posedge clk) disable iff (!reset) done == done_exp)
        else begin
            timing_errors++;
            $display("Mismatch at %0t: done expected %b, got %b",
                     $time, $sampled(done_exp), $sampled(done));
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (!reset) done |=> !done)
        else begin
            timing_errors++;
            $display("At %0t done stayed high for more than one cycle", $time);
        end

    // Zero from reset, and from each accepted start up to the done edge
    result_masked: assert property (@(posedge clk) disable iff (!reset)
                                    (since_accept < done_edge) |-> (result == '0))
        else begin
            value_errors++;
            $display("Mismatch at %0t: result expected %h, got %h",
                     $time, {$bits(div_result_t){1'b0}}, $sampled(result));
        end

    result_steady: assert property (@(posedge clk) disable iff (!reset)
                                    (since_accept > done_edge) |-> (result == result_prev))
        else begin
            value_errors++;
            $display("Mismatch at %0t: result expected %h, got %h",
                     $time, $sampled(result_prev), $sampled(result));
        end

    // Value checks at the done pulse
    always @(negedge clk) begin
        if (reset && done) begin
            done_count++;
            assert (result.quotient == exp_result.quotient)
                else begin
                    value_errors++;
                    $display("Mismatch at %0t: result.quotient expected %h, got %h",
                             $time, exp_result.quotient, result.quotient);
                end
            assert (result.remainder == exp_result.remainder)
                else begin
                    value_errors++;
                    $display("Mismatch at %0t: result.remainder expected %h, got %h",
                             $time, exp_result.remainder, result.remainder);
                end
            assert (result.div_by_zero == exp_result.div_by_zero)
                else begin
                    value_errors++;
                    $display("Mismatch at %0t: result.div_by_zero expected %b, got %b",
                             $time, exp_result.div_by_zero, result.div_by_zero);
                end
        end
    end

    function automatic div_result_t model_result(input logic [div_width-1:0] dividend,
                                                 input logic [div_width-1:0] divisor);
        div_result_t r;
        if (divisor == '0) begin
            // Zero divisor gives all ones and the dividend back
            r.quotient    = '1;
            r.remainder   = dividend;
            r.div_by_zero = 1'b1;
        end else begin
            r.quotient    = dividend / divisor;
            r.remainder   = dividend % divisor;
            r.div_by_zero = 1'b0;
        end
        return r;
    endfunction

    // One division
    // A nonzero busy_pulse_at adds a start pulse on that edge while busy
    task automatic issue_division(input logic [div_width-1:0] dividend,
                                  input logic [div_width-1:0] divisor,
                                  input int busy_pulse_at);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        @(negedge clk);
        request.dividend = dividend;
        request.divisor  = divisor;
        exp_result       = model_result(dividend, divisor);
        start            = 1'b1;
        issued_count++;
        while (!seen && cycles < done_limit) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                seen = 1'b1;
            end
            start = (cycles == busy_pulse_at);
            if (cycles == busy_pulse_at) begin
                // A leaked request would flip the divide-by-zero flag
                request.dividend = div_width'($urandom);
                request.divisor  = (divisor == '0) ? div_width'($urandom | 1) : '0;
            end
        end
        start = 1'b0;
        assert (seen)
            else begin
                timing_errors++;
                $display("No done pulse within %0d cycles of the start issued before %0t",
                         done_limit, $time);
            end
    endtask

    task automatic run_random(input int count);
        logic [div_width-1:0] dividend;
        logic [div_width-1:0] divisor;
        for (int i = 0; i < count; i++) begin
            dividend = div_width'($urandom);
            // Narrow divisors now and then so quotients spread out
            divisor  = div_width'($urandom) >> $urandom_range(div_width - 1, 0);
            issue_division(dividend, divisor, 0);
        end
    endtask

    initial begin
        void'($urandom(32'h24db_2856));
        reset   = 1'b0;
        start   = 1'b0;
        request = '0;
        exp_result = '0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);

        // Corner cases
        issue_division(16'h0000, 16'h0001, 0);
        issue_division(16'h0000, 16'h0005, 0);
        issue_division(16'h1234, 16'h0001, 0);
        issue_division(16'h0309, 16'h0309, 0);
        issue_division(16'h0005, 16'h0009, 0);
        issue_division(16'hffff, 16'hffff, 0);
        issue_division(16'hffff, 16'h0001, 0);
        issue_division(16'hffff, 16'h0002, 0);
        issue_division(16'h0001, 16'hffff, 0);

        // Divide by zero
        issue_division(16'h1234, 16'h0000, 0);
        issue_division(16'h0000, 16'h0000, 0);
        issue_division(16'hffff, 16'h0000, 0);

        // Starts while busy early in the run and on the last busy edge
        issue_division(16'hbeef, 16'h0013, 5);
        issue_division(16'h8001, 16'h00ff, busy_last);

        run_random(num_random);

        repeat (4) @(negedge clk);
        assert (done_count == issued_count)
            else begin
                timing_errors++;
                $display("Expected %0d done pulses, counted %0d", issued_count, done_count);
            end

        $display("Summary: value errors %0d, timing errors %0d", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete",
                 watchdog_cycles);
        $display("Summary: value errors %0d, timing errors %0d", value_errors, timing_errors);
        $display("Errors found");
        $finish;
    end

endmodule
